/* hdl/wb_pipe_macros.svh */
`ifndef WB_PIPE_MACROS_SVH
`define WB_PIPE_MACROS_SVH

// Shared sizing for the write-back pipeline

// Register and data width in bits
`define WB_XLEN 32

// Architectural register count, x0 included
`define WB_NUM_REGS 32

// Default entries in each response FIFO
// Two entries let a response land while the head is being consumed
`define WB_RESP_DEPTH 2

`endif

/* hdl/wb_pipe_pkg.sv */
`include "wb_pipe_macros.svh"

package wb_pipe_pkg;

  // Register index wide enough for every architectural register
  typedef logic [$clog2(`WB_NUM_REGS)-1:0] rf_addr_t;

  // Protection status returned with each load
  typedef enum logic [1:0] {
    MPU_OK       = 2'b00,
    MPU_RE_FAULT = 2'b01,
    MPU_WR_FAULT = 2'b10
  } mpu_status_e;

  ////////////////////////////////////////////////////////////////////////////
  // FIFO payloads
  ////////////////////////////////////////////////////////////////////////////

  // One load response from the data bus
  typedef struct packed {
    logic [`WB_XLEN-1:0] rdata;
    mpu_status_e         mpu_status;
  } lsu_resp_t;

  // One coprocessor result
  typedef struct packed {
    logic [`WB_XLEN-1:0] data;
    logic                exc;      // Coprocessor raised a synchronous exception
  } xif_result_t;

  ////////////////////////////////////////////////////////////////////////////
  // EX/WB pipeline register contents
  ////////////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic                rf_we;
    rf_addr_t            rf_waddr;
    logic [`WB_XLEN-1:0] rf_wdata;   // ALU result that late sources ignore
    logic                lsu_en;     // Result comes from the load FIFO
    logic                xif_en;     // Result comes from the coprocessor FIFO
  } ex_wb_pipe_t;

endpackage

/* hdl/wb_ex_wb_reg.sv */
`timescale 1ns/1ps

`include "wb_pipe_macros.svh"

module wb_ex_wb_reg (
  input  logic                   clk,
  input  logic                   rst_n_i,

  // EX side
  input  logic                   ex_valid_i,
  output logic                   ex_ready_o,
  input  logic                   ex_rf_we_i,
  input  wb_pipe_pkg::rf_addr_t  ex_rf_waddr_i,
  input  logic [`WB_XLEN-1:0]    ex_rf_wdata_i,
  input  logic                   ex_lsu_en_i,
  input  logic                   ex_xif_en_i,

  // WB side
  input  logic                   wb_ready_i,
  input  logic                   kill_wb_i,
  output logic                   instr_valid_o,
  output wb_pipe_pkg::ex_wb_pipe_t pipe_o
);

  logic                     instr_valid_q;
  wb_pipe_pkg::ex_wb_pipe_t pipe_q;
  logic                     load_en;

  ////////////////////////////////////////////////////////////////////////////
  // Handshake toward EX
  ////////////////////////////////////////////////////////////////////////////

  // Room for a new instruction when empty, when the current one retires,
  // or when the current one is being killed
  assign ex_ready_o = !instr_valid_q || wb_ready_i || kill_wb_i;

  // Payload only moves on an actual transfer
  assign load_en = ex_valid_i && ex_ready_o;

  ////////////////////////////////////////////////////////////////////////////
  // Valid flag
  ////////////////////////////////////////////////////////////////////////////

  // Follows EX whenever the slot frees up
  // A kill empties the slot unless a new instruction arrives in its place
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      instr_valid_q <= 1'b0;
    end else if (ex_ready_o) begin
      instr_valid_q <= ex_valid_i;
    end
  end

  // Instruction payload qualified by the valid flag
  always_ff @(posedge clk) begin
    if (load_en) begin
      pipe_q.rf_we    <= ex_rf_we_i;
      pipe_q.rf_waddr <= ex_rf_waddr_i;
      pipe_q.rf_wdata <= ex_rf_wdata_i;
      pipe_q.lsu_en   <= ex_lsu_en_i;
      pipe_q.xif_en   <= ex_xif_en_i;
    end
  end

  assign instr_valid_o = instr_valid_q;
  assign pipe_o        = pipe_q;

endmodule

/* hdl/wb_resp_fifo.sv */
`timescale 1ns/1ps

`include "wb_pipe_macros.svh"

module wb_resp_fifo #(
  parameter int  DEPTH     = `WB_RESP_DEPTH,
  parameter type payload_t = logic [`WB_XLEN-1:0]
) (
  input  logic     clk,
  input  logic     rst_n_i,

  // Producer side
  input  logic     push_valid_i,
  output logic     push_ready_o,
  input  payload_t push_data_i,

  // Consumer side
  // A pop is a request and only acts on a valid head
  output logic     head_valid_o,
  output payload_t head_data_o,
  input  logic     pop_i
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(DEPTH - 1);
  localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(DEPTH);

  payload_t         mem_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             push;
  logic             pop;

  // Full drops ready so a push never lands on a full buffer
  assign push_ready_o = (count_q != FULL_CNT);
  assign head_valid_o = (count_q != '0);

  assign push = push_valid_i && push_ready_o;
  assign pop  = pop_i && head_valid_o;

  ////////////////////////////////////////////////////////////////////////////
  // Pointers and occupancy
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == LAST_PTR) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == LAST_PTR) ? '0 : rd_ptr_q + 1'b1;
      end
      // Simultaneous push and pop leave the count alone
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  // Storage
  always_ff @(posedge clk) begin
    if (push) begin
      mem_q[wr_ptr_q] <= push_data_i;
    end
  end

  // Head is read straight from storage
  assign head_data_o = mem_q[rd_ptr_q];

endmodule

/* hdl/wb_stage.sv */
`timescale 1ns/1ps

`include "wb_pipe_macros.svh"

module wb_stage (
  // Instruction from the EX/WB register
  input  logic                     instr_valid_i,
  input  wb_pipe_pkg::ex_wb_pipe_t pipe_i,

  // Controller
  input  logic                     halt_wb_i,
  input  logic                     kill_wb_i,

  // Load response FIFO head
  input  logic                     lsu_head_valid_i,
  input  wb_pipe_pkg::lsu_resp_t   lsu_head_i,
  output logic                     lsu_pop_o,

  // Coprocessor result FIFO head
  input  logic                     xif_head_valid_i,
  input  wb_pipe_pkg::xif_result_t xif_head_i,
  output logic                     xif_pop_o,

  // Register file write port
  output logic                     rf_we_o,
  output wb_pipe_pkg::rf_addr_t    rf_waddr_o,
  output logic [`WB_XLEN-1:0]      rf_wdata_o,

  // Stage status
  output logic                     wb_ready_o,
  output logic                     wb_valid_o,
  output logic                     data_stall_o,
  output logic                     exc_o
);

  logic live;
  logic lsu_waiting;
  logic xif_waiting;
  logic retire;
  logic lsu_exception;
  logic xif_exception;
  logic exception;

  // Instruction may act this cycle
  assign live = instr_valid_i && !kill_wb_i && !halt_wb_i;

  ////////////////////////////////////////////////////////////////////////////
  // Late result tracking
  ////////////////////////////////////////////////////////////////////////////

  // Load or offloaded instruction without its response yet
  assign lsu_waiting = pipe_i.lsu_en && !lsu_head_valid_i;
  assign xif_waiting = pipe_i.xif_en && !xif_head_valid_i;

  assign retire = live && !lsu_waiting && !xif_waiting;

  // Fault info only matters once the matching head is present
  assign lsu_exception = pipe_i.lsu_en && (lsu_head_i.mpu_status != wb_pipe_pkg::MPU_OK);
  assign xif_exception = pipe_i.xif_en && xif_head_i.exc;
  assign exception     = lsu_exception || xif_exception;

  // Consume exactly the head this instruction used
  assign lsu_pop_o = retire && pipe_i.lsu_en;
  assign xif_pop_o = retire && pipe_i.xif_en;

  ////////////////////////////////////////////////////////////////////////////
  // Register file write
  ////////////////////////////////////////////////////////////////////////////

  // Faulting loads and excepting coprocessor results never reach the file
  assign rf_we_o    = retire && pipe_i.rf_we && !exception;
  assign rf_waddr_o = pipe_i.rf_waddr;

  // Load data first, then coprocessor data, else the ALU result
  always_comb begin
    if (pipe_i.lsu_en) begin
      rf_wdata_o = lsu_head_i.rdata;
    end else if (pipe_i.xif_en) begin
      rf_wdata_o = xif_head_i.data;
    end else begin
      rf_wdata_o = pipe_i.rf_wdata;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stage status
  ////////////////////////////////////////////////////////////////////////////

  // Free for the next instruction when empty or retiring now
  assign wb_ready_o = !instr_valid_i || retire;

  // One pulse per retired instruction including exceptions
  assign wb_valid_o = retire;
  assign exc_o      = retire && exception;

  // Load held up by the data bus
  assign data_stall_o = live && lsu_waiting;

endmodule

/* hdl/wb_regfile.sv */
`timescale 1ns/1ps

`include "wb_pipe_macros.svh"

module wb_regfile (
  input  logic                  clk,
  input  logic                  rst_n_i,

  // Write port from WB
  input  logic                  we_i,
  input  wb_pipe_pkg::rf_addr_t waddr_i,
  input  logic [`WB_XLEN-1:0]   wdata_i,

  // Read port
  input  wb_pipe_pkg::rf_addr_t raddr_i,
  output logic [`WB_XLEN-1:0]   rdata_o
);

  // x0 has no storage
  logic [`WB_XLEN-1:0] regs_q [1:`WB_NUM_REGS-1];
  logic                wr_en;

  // Writes aimed at x0 are dropped
  assign wr_en = we_i && (waddr_i != '0);

  ////////////////////////////////////////////////////////////////////////////
  // Storage
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 1; i < `WB_NUM_REGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (wr_en) begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

  // Combinational read with x0 tied to zero
  always_comb begin
    if (raddr_i == '0) begin
      rdata_o = '0;
    end else begin
      rdata_o = regs_q[raddr_i];
    end
  end

endmodule

/* hdl/wb_pipe_top.sv */
`timescale 1ns/1ps

`include "wb_pipe_macros.svh"

module wb_pipe_top (
  input  logic                    clk,
  input  logic                    rst_n_i,

  // EX channel
  input  logic                    ex_valid_i,
  output logic                    ex_ready_o,
  input  logic                    ex_rf_we_i,
  input  wb_pipe_pkg::rf_addr_t   ex_rf_waddr_i,
  input  logic [`WB_XLEN-1:0]     ex_rf_wdata_i,
  input  logic                    ex_lsu_en_i,
  input  logic                    ex_xif_en_i,

  // Load response channel
  input  logic                    lsu_rvalid_i,
  output logic                    lsu_rready_o,
  input  logic [`WB_XLEN-1:0]     lsu_rdata_i,
  input  wb_pipe_pkg::mpu_status_e lsu_mpu_status_i,

  // Coprocessor result channel
  input  logic                    xif_result_valid_i,
  output logic                    xif_result_ready_o,
  input  logic [`WB_XLEN-1:0]     xif_result_data_i,
  input  logic                    xif_result_exc_i,

  // Controller
  input  logic                    halt_wb_i,
  input  logic                    kill_wb_i,

  // Register read port
  input  wb_pipe_pkg::rf_addr_t   rf_raddr_i,
  output logic [`WB_XLEN-1:0]     rf_rdata_o,

  // Retire status
  output logic                    wb_valid_o,
  output wb_pipe_pkg::rf_addr_t   wb_rd_o,
  output logic                    wb_we_o,
  output logic                    data_stall_o,
  output logic                    exc_o
);

  logic                     instr_valid;
  wb_pipe_pkg::ex_wb_pipe_t ex_wb_pipe;
  logic                     wb_ready;
  logic                     lsu_head_valid;
  wb_pipe_pkg::lsu_resp_t   lsu_head;
  logic                     lsu_pop;
  logic                     xif_head_valid;
  wb_pipe_pkg::xif_result_t xif_head;
  logic                     xif_pop;
  logic [`WB_XLEN-1:0]      rf_wdata;

  ////////////////////////////////////////////////////////////////////////////
  // EX/WB register
  ////////////////////////////////////////////////////////////////////////////

  wb_ex_wb_reg i_ex_wb_reg (
    .clk           (clk),
    .rst_n_i       (rst_n_i),
    .ex_valid_i    (ex_valid_i),
    .ex_ready_o    (ex_ready_o),
    .ex_rf_we_i    (ex_rf_we_i),
    .ex_rf_waddr_i (ex_rf_waddr_i),
    .ex_rf_wdata_i (ex_rf_wdata_i),
    .ex_lsu_en_i   (ex_lsu_en_i),
    .ex_xif_en_i   (ex_xif_en_i),
    .wb_ready_i    (wb_ready),
    .kill_wb_i     (kill_wb_i),
    .instr_valid_o (instr_valid),
    .pipe_o        (ex_wb_pipe)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Late result buffers
  ////////////////////////////////////////////////////////////////////////////

  // Load responses
  wb_resp_fifo #(
    .DEPTH     (`WB_RESP_DEPTH),
    .payload_t (wb_pipe_pkg::lsu_resp_t)
  ) i_lsu_fifo (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .push_valid_i (lsu_rvalid_i),
    .push_ready_o (lsu_rready_o),
    .push_data_i  (wb_pipe_pkg::lsu_resp_t'{rdata: lsu_rdata_i,
                                            mpu_status: lsu_mpu_status_i}),
    .head_valid_o (lsu_head_valid),
    .head_data_o  (lsu_head),
    .pop_i        (lsu_pop)
  );

  // Coprocessor results
  wb_resp_fifo #(
    .DEPTH     (`WB_RESP_DEPTH),
    .payload_t (wb_pipe_pkg::xif_result_t)
  ) i_xif_fifo (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .push_valid_i (xif_result_valid_i),
    .push_ready_o (xif_result_ready_o),
    .push_data_i  (wb_pipe_pkg::xif_result_t'{data: xif_result_data_i,
                                              exc: xif_result_exc_i}),
    .head_valid_o (xif_head_valid),
    .head_data_o  (xif_head),
    .pop_i        (xif_pop)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Write-back stage and register file
  ////////////////////////////////////////////////////////////////////////////

  // Write enable and address also go out as retire status
  wb_stage i_wb_stage (
    .instr_valid_i    (instr_valid),
    .pipe_i           (ex_wb_pipe),
    .halt_wb_i        (halt_wb_i),
    .kill_wb_i        (kill_wb_i),
    .lsu_head_valid_i (lsu_head_valid),
    .lsu_head_i       (lsu_head),
    .lsu_pop_o        (lsu_pop),
    .xif_head_valid_i (xif_head_valid),
    .xif_head_i       (xif_head),
    .xif_pop_o        (xif_pop),
    .rf_we_o          (wb_we_o),
    .rf_waddr_o       (wb_rd_o),
    .rf_wdata_o       (rf_wdata),
    .wb_ready_o       (wb_ready),
    .wb_valid_o       (wb_valid_o),
    .data_stall_o     (data_stall_o),
    .exc_o            (exc_o)
  );

  wb_regfile i_regfile (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .we_i    (wb_we_o),
    .waddr_i (wb_rd_o),
    .wdata_i (rf_wdata),
    .raddr_i (rf_raddr_i),
    .rdata_o (rf_rdata_o)
  );

endmodule

/* dv/wb_tb_clkgen.sv */
`timescale 1ns/1ps

module wb_tb_clkgen #(
  parameter int PERIOD_NS  = 8,
  parameter int RST_CYCLES = 3
) (
  output logic clk_o,
  output logic rst_n_o
);

  // Free running clock that starts low
  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  // Reset held for a few cycles and released on a falling edge
  initial begin
    rst_n_o = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;
  end

endmodule

/* dv/wb_pipe_tb.sv */
`timescale 1ns/1ps

`include "wb_pipe_macros.svh"

module wb_pipe_tb;

  localparam int SEED            = 20;
  localparam int CLK_PERIOD_NS   = 8;
  localparam int SAMPLE_DLY      = 2;     // Sample point after the falling edge
  localparam int NUM_TESTS       = 6;
  localparam int TEST_BUDGET_CYC = 3000;  // Worst case per test including the random mix
  localparam int NUM_RANDOM      = 200;

  localparam logic [1:0] KIND_ALU  = 2'd0;
  localparam logic [1:0] KIND_LOAD = 2'd1;
  localparam logic [1:0] KIND_XIF  = 2'd2;

  // One instruction with the late response it will get
  typedef struct packed {
    logic [1:0]          kind;
    logic                we;
    logic [4:0]          rd;
    logic [`WB_XLEN-1:0] data;    // ALU result or late response data
    logic [1:0]          status;  // Load protection status
    logic                exc;     // Coprocessor exception
    logic [3:0]          delay;   // Cycles before the response is offered
  } instr_t;

  logic clk;
  logic rst_n;

  logic                       ex_valid_i;
  logic                       ex_ready_o;
  logic                       ex_rf_we_i;
  wb_pipe_pkg::rf_addr_t      ex_rf_waddr_i;
  logic [`WB_XLEN-1:0]        ex_rf_wdata_i;
  logic                       ex_lsu_en_i;
  logic                       ex_xif_en_i;
  logic                       lsu_rvalid_i;
  logic                       lsu_rready_o;
  logic [`WB_XLEN-1:0]        lsu_rdata_i;
  wb_pipe_pkg::mpu_status_e   lsu_mpu_status_i;
  logic                       xif_result_valid_i;
  logic                       xif_result_ready_o;
  logic [`WB_XLEN-1:0]        xif_result_data_i;
  logic                       xif_result_exc_i;
  logic                       halt_wb_i;
  logic                       kill_wb_i;
  wb_pipe_pkg::rf_addr_t      rf_raddr_i;
  logic [`WB_XLEN-1:0]        rf_rdata_o;
  logic                       wb_valid_o;
  wb_pipe_pkg::rf_addr_t      wb_rd_o;
  logic                       wb_we_o;
  logic                       data_stall_o;
  logic                       exc_o;

  // Reference state
  logic [`WB_XLEN-1:0] model [`WB_NUM_REGS];
  instr_t              wb_q[$];        // Instruction sitting in WB
  instr_t              lsu_pend_q[$];  // Load responses still to offer
  instr_t              xif_pend_q[$];  // Coprocessor results still to offer
  instr_t              cur_instr;      // Payload currently on the EX channel
  int                  lsu_avail;      // Entries in the load FIFO
  int                  xif_avail;
  int                  issued_cnt;
  int                  done_cnt;       // Retired or killed
  int                  err_cnt;
  int                  fail_cnt;

  wb_tb_clkgen #(.PERIOD_NS(CLK_PERIOD_NS), .RST_CYCLES(3)) i_clkgen (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  wb_pipe_top i_dut (
    .clk (clk), .rst_n_i (rst_n),
    .ex_valid_i (ex_valid_i), .ex_ready_o (ex_ready_o), .ex_rf_we_i (ex_rf_we_i),
    .ex_rf_waddr_i (ex_rf_waddr_i), .ex_rf_wdata_i (ex_rf_wdata_i),
    .ex_lsu_en_i (ex_lsu_en_i), .ex_xif_en_i (ex_xif_en_i),
    .lsu_rvalid_i (lsu_rvalid_i), .lsu_rready_o (lsu_rready_o),
    .lsu_rdata_i (lsu_rdata_i), .lsu_mpu_status_i (lsu_mpu_status_i),
    .xif_result_valid_i (xif_result_valid_i), .xif_result_ready_o (xif_result_ready_o),
    .xif_result_data_i (xif_result_data_i), .xif_result_exc_i (xif_result_exc_i),
    .halt_wb_i (halt_wb_i), .kill_wb_i (kill_wb_i),
    .rf_raddr_i (rf_raddr_i), .rf_rdata_o (rf_rdata_o),
    .wb_valid_o (wb_valid_o), .wb_rd_o (wb_rd_o), .wb_we_o (wb_we_o),
    .data_stall_o (data_stall_o), .exc_o (exc_o)
  );

  task automatic flag_mismatch(input string msg);
    err_cnt++;
    $display("ERR @%0t: %s", $time, msg);
  endtask

  task automatic note_failure(input string msg);
    fail_cnt++;
    $display("%s", msg);
  endtask

  task automatic print_counts();
    $display("Value errors: %0d, other failures: %0d, instructions done: %0d",
             err_cnt, fail_cnt, done_cnt);
  endtask

  function automatic instr_t make_instr(input logic [1:0] kind, input logic [4:0] rd,
                                        input logic [1:0] status, input logic exc,
                                        input logic [3:0] delay);
    instr_t ins;
    ins.kind   = kind;
    ins.we     = 1'b1;
    ins.rd     = rd;
    ins.data   = $urandom();
    ins.status = status;
    ins.exc    = exc;
    ins.delay  = delay;
    return ins;
  endfunction

  //////////////////////////////////////////////////////////////////////////
  // Drivers that are called and return on a falling edge
  //////////////////////////////////////////////////////////////////////////

  // Hold the instruction on EX until the pipeline register takes it
  task automatic send_instr(input instr_t ins);
    cur_instr     = ins;
    ex_valid_i    = 1'b1;
    ex_rf_we_i    = ins.we;
    ex_rf_waddr_i = ins.rd;
    // Junk ALU data for late sources that the stage must not pick
    ex_rf_wdata_i = (ins.kind == KIND_ALU) ? ins.data : $urandom();
    ex_lsu_en_i   = (ins.kind == KIND_LOAD);
    ex_xif_en_i   = (ins.kind == KIND_XIF);
    if (ins.kind == KIND_LOAD) lsu_pend_q.push_back(ins);
    if (ins.kind == KIND_XIF) xif_pend_q.push_back(ins);
    #SAMPLE_DLY;
    while (!ex_ready_o) begin
      @(negedge clk);
      #SAMPLE_DLY;
    end
    @(negedge clk);
    ex_valid_i = 1'b0;
    issued_cnt++;
  endtask

  // Until every handed over instruction has left WB
  task automatic drain();
    while (done_cnt != issued_cnt) @(negedge clk);
  endtask

  task automatic check_reg(input wb_pipe_pkg::rf_addr_t addr);
    rf_raddr_i = addr;
    #SAMPLE_DLY;
    assert (rf_rdata_o == model[addr])
      else flag_mismatch($sformatf("x%0d reads %h, expected %h", addr, rf_rdata_o,
                                   model[addr]));
    @(negedge clk);
  endtask

  task automatic check_all_regs();
    for (int i = 0; i < `WB_NUM_REGS; i++) check_reg(wb_pipe_pkg::rf_addr_t'(i));
  endtask

  // Offers load responses in issue order after each one's delay
  initial forever begin : lsu_responder
    instr_t r;
    @(negedge clk);
    lsu_rvalid_i = 1'b0;
    if (lsu_pend_q.size() != 0) begin
      r = lsu_pend_q.pop_front();
      repeat (r.delay) @(negedge clk);
      lsu_rvalid_i     = 1'b1;
      lsu_rdata_i      = r.data;
      lsu_mpu_status_i = wb_pipe_pkg::mpu_status_e'(r.status);
      #SAMPLE_DLY;
      while (!lsu_rready_o) begin
        @(negedge clk);
        #SAMPLE_DLY;
      end
    end
  end

  // Offers coprocessor results the same way
  initial forever begin : xif_responder
    instr_t r;
    @(negedge clk);
    xif_result_valid_i = 1'b0;
    if (xif_pend_q.size() != 0) begin
      r = xif_pend_q.pop_front();
      repeat (r.delay) @(negedge clk);
      xif_result_valid_i = 1'b1;
      xif_result_data_i  = r.data;
      xif_result_exc_i   = r.exc;
      #SAMPLE_DLY;
      while (!xif_result_ready_o) begin
        @(negedge clk);
        #SAMPLE_DLY;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////////
  // Reference model and checks sampled before each rising edge
  //////////////////////////////////////////////////////////////////////////

  always begin : monitor
    instr_t head;
    logic   in_wb;
    logic   exc_exp;
    logic   retire_exp;
    @(negedge clk);
    #SAMPLE_DLY;
    if (rst_n) begin
      in_wb   = (wb_q.size() != 0);
      head    = in_wb ? wb_q[0] : '0;
      exc_exp = (head.kind == KIND_LOAD && head.status != wb_pipe_pkg::MPU_OK) ||
                (head.kind == KIND_XIF && head.exc);
      // Retire once the matching response is queued, unless halted or killed
      retire_exp = in_wb && !halt_wb_i && !kill_wb_i &&
                   (head.kind == KIND_ALU || (head.kind == KIND_LOAD && lsu_avail > 0) ||
                    (head.kind == KIND_XIF && xif_avail > 0));
      assert (wb_valid_o == retire_exp)
        else flag_mismatch($sformatf("wb_valid_o %0b, expected %0b", wb_valid_o, retire_exp));
      assert (ex_ready_o == (!in_wb || retire_exp || kill_wb_i))
        else flag_mismatch($sformatf("ex_ready_o %0b with WB %0s", ex_ready_o,
                                     in_wb ? "full" : "empty"));
      assert (data_stall_o == (in_wb && !halt_wb_i && !kill_wb_i &&
                               head.kind == KIND_LOAD && lsu_avail == 0))
        else flag_mismatch($sformatf("data_stall_o %0b is wrong", data_stall_o));
      // Full FIFO refuses new responses
      assert (lsu_rready_o == (lsu_avail < `WB_RESP_DEPTH))
        else flag_mismatch($sformatf("lsu_rready_o %0b with %0d queued", lsu_rready_o,
                                     lsu_avail));
      assert (xif_result_ready_o == (xif_avail < `WB_RESP_DEPTH))
        else flag_mismatch($sformatf("xif_result_ready_o %0b with %0d queued",
                                     xif_result_ready_o, xif_avail));
      assert (exc_o == (retire_exp && exc_exp))
        else flag_mismatch($sformatf("exc_o %0b, expected %0b", exc_o, retire_exp && exc_exp));
      // Faults suppress the write
      assert (wb_we_o == (retire_exp && head.we && !exc_exp))
        else flag_mismatch($sformatf("wb_we_o %0b is wrong", wb_we_o));
      if (retire_exp) begin
        if (head.we && !exc_exp) begin
          assert (wb_rd_o == head.rd)
            else flag_mismatch($sformatf("wb_rd_o %0d, expected %0d", wb_rd_o, head.rd));
          if (head.rd != '0) model[head.rd] = head.data;
        end
        if (head.kind == KIND_LOAD) lsu_avail--;
        if (head.kind == KIND_XIF) xif_avail--;
      end
      if (retire_exp || (kill_wb_i && in_wb)) begin
        void'(wb_q.pop_front());
        done_cnt++;
      end
      if (lsu_rvalid_i && lsu_rready_o) lsu_avail++;
      if (xif_result_valid_i && xif_result_ready_o) xif_avail++;
      if (ex_valid_i && ex_ready_o) wb_q.push_back(cur_instr);
    end
  end

  // Exceptions only ride on a retire
  assert property (@(posedge clk) disable iff (!rst_n) exc_o |-> wb_valid_o)
    else note_failure("Exception flagged without a retiring instruction");

  assert property (@(posedge clk) disable iff (!rst_n) kill_wb_i |-> !wb_valid_o)
    else note_failure("Killed instruction still retired");

  //////////////////////////////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////////////////////////////

  // Back to back ALU writes with one aimed at x0
  task automatic run_alu_burst();
    for (int i = 0; i < 12; i++) begin
      send_instr(make_instr(KIND_ALU, 5'((i == 3) ? 0 : $urandom_range(31, 1)),
                            wb_pipe_pkg::MPU_OK, 1'b0, 4'd0));
    end
    drain();
    check_all_regs();
  endtask

  // Two late instructions whose responses both queue up while WB is halted
  // The matching FIFO runs full and has to drop its input ready
  task automatic fill_fifo_while_halted(input logic [1:0] kind, input logic [4:0] rd);
    halt_wb_i = 1'b1;
    send_instr(make_instr(kind, rd, wb_pipe_pkg::MPU_OK, 1'b0, 4'd0));
    fork
      send_instr(make_instr(kind, 5'(rd + 1), wb_pipe_pkg::MPU_OK, 1'b0, 4'd0));
      begin
        repeat (8) @(negedge clk);
        halt_wb_i = 1'b0;
      end
    join
    drain();
    check_reg(rd);
    check_reg(5'(rd + 1));
  endtask

  task automatic run_loads();
    send_instr(make_instr(KIND_LOAD, 5'd5, wb_pipe_pkg::MPU_OK, 1'b0, 4'd3));
    send_instr(make_instr(KIND_LOAD, 5'd4, wb_pipe_pkg::MPU_OK, 1'b0, 4'd0));
    drain();
    check_reg(5'd5);
    check_reg(5'd4);
    fill_fifo_while_halted(KIND_LOAD, 5'd11);
  endtask

  // Both fault kinds must leave x6 alone
  task automatic run_faults();
    send_instr(make_instr(KIND_ALU, 5'd6, wb_pipe_pkg::MPU_OK, 1'b0, 4'd0));
    send_instr(make_instr(KIND_LOAD, 5'd6, wb_pipe_pkg::MPU_RE_FAULT, 1'b0, 4'd2));
    send_instr(make_instr(KIND_LOAD, 5'd6, wb_pipe_pkg::MPU_WR_FAULT, 1'b0, 4'd0));
    drain();
    check_reg(5'd6);
  endtask

  task automatic run_coproc();
    send_instr(make_instr(KIND_XIF, 5'd7, wb_pipe_pkg::MPU_OK, 1'b0, 4'd2));
    send_instr(make_instr(KIND_XIF, 5'd7, wb_pipe_pkg::MPU_OK, 1'b1, 4'd1));
    drain();
    check_reg(5'd7);
    fill_fifo_while_halted(KIND_XIF, 5'd13);
  endtask

  task automatic run_halt_kill();
    halt_wb_i = 1'b1;
    send_instr(make_instr(KIND_ALU, 5'd8, wb_pipe_pkg::MPU_OK, 1'b0, 4'd0));
    // Second instruction backs up behind the halted one
    fork
      send_instr(make_instr(KIND_ALU, 5'd9, wb_pipe_pkg::MPU_OK, 1'b0, 4'd0));
      begin
        repeat (4) @(negedge clk);
        halt_wb_i = 1'b0;
      end
    join
    drain();
    // Killed while it sits halted in WB
    halt_wb_i = 1'b1;
    send_instr(make_instr(KIND_ALU, 5'd10, wb_pipe_pkg::MPU_OK, 1'b0, 4'd0));
    kill_wb_i = 1'b1;
    @(negedge clk);
    kill_wb_i = 1'b0;
    halt_wb_i = 1'b0;
    drain();
    check_reg(5'd8);
    check_reg(5'd9);
    check_reg(5'd10);
  endtask

  task automatic run_random();
    instr_t ins;
    for (int i = 0; i < NUM_RANDOM; i++) begin
      ins = make_instr(2'($urandom_range(2, 0)), 5'($urandom_range(31, 0)),
                       wb_pipe_pkg::MPU_OK, 1'b0, 4'($urandom_range(5, 0)));
      ins.we = ($urandom_range(3, 0) != 0);
      if ($urandom_range(3, 0) == 0) ins.status = 2'($urandom_range(2, 1));
      ins.exc = ($urandom_range(4, 0) == 0);
      send_instr(ins);
    end
    drain();
    check_all_regs();
  endtask

  initial begin : main
    void'($urandom(SEED));
    ex_valid_i         = 1'b0;
    ex_rf_we_i         = 1'b0;
    ex_rf_waddr_i      = '0;
    ex_rf_wdata_i      = '0;
    ex_lsu_en_i        = 1'b0;
    ex_xif_en_i        = 1'b0;
    lsu_rvalid_i       = 1'b0;
    lsu_rdata_i        = '0;
    lsu_mpu_status_i   = wb_pipe_pkg::MPU_OK;
    xif_result_valid_i = 1'b0;
    xif_result_data_i  = '0;
    xif_result_exc_i   = 1'b0;
    halt_wb_i          = 1'b0;
    kill_wb_i          = 1'b0;
    rf_raddr_i         = '0;
    cur_instr          = '0;
    foreach (model[i]) model[i] = '0;
    @(posedge rst_n);
    @(negedge clk);
    run_alu_burst();
    run_loads();
    run_faults();
    run_coproc();
    run_halt_kill();
    run_random();
    print_counts();
    if (err_cnt == 0 && fail_cnt == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

  // Ends a hung run
  initial begin : watchdog
    #(NUM_TESTS * TEST_BUDGET_CYC * CLK_PERIOD_NS);
    $display("Watchdog expired before all tests finished");
    print_counts();
    $display("Simulation FAILED");
    $finish;
  end

endmodule

/* wb_pipe.f */
+incdir+hdl
hdl/wb_pipe_pkg.sv
hdl/wb_ex_wb_reg.sv
hdl/wb_resp_fifo.sv
hdl/wb_stage.sv
hdl/wb_regfile.sv
hdl/wb_pipe_top.sv
dv/wb_tb_clkgen.sv
dv/wb_pipe_tb.sv

/* run_sim.sh */
#!/bin/sh
# Compile and run the write-back pipeline testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -j 0 \
  --top-module wb_pipe_tb -f wb_pipe.f > "$LOG" 2>&1 \
  && ./obj_dir/Vwb_pipe_tb >> "$LOG" 2>&1 \
  || echo "Build or simulation stopped with an error" >> "$LOG"

# Verdict comes from the simulation log only
grep -q "Simulation PASSED" "$LOG" && echo "PASS" && exit 0 \
  || { cat "$LOG"; echo "FAIL"; exit 1; }
